// File: Makefile
# Verilator build and run for the ALU cluster

VERILATOR ?= verilator
TOP       ?= tb_alu_cluster
RTL_TOP   ?= alu_cluster
FILELIST  ?= alu_cluster.f
BUILD_DIR ?= build
LOG       ?= $(BUILD_DIR)/sim.log
TIMESCALE ?= 1ns/1ps
VFLAGS    ?= --binary --timing --assert --timescale $(TIMESCALE)
PASS_MSG  := All tests passed!

SRCS     := $(shell grep -v '^+' $(FILELIST))
RTL_SRCS := $(shell grep '^hw/' $(FILELIST))

.PHONY: all build run lint clean

all: run

build: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -qF '$(PASS_MSG)' $(LOG); then echo "Simulation passed"; \
	else echo "Simulation failed"; exit 1; fi

lint:
	$(VERILATOR) --lint-only --timing --timescale $(TIMESCALE) $(RTL_SRCS) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only --timing --timescale $(TIMESCALE) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR)

// File: alu_cluster.f
hw/alu_pkg.sv
hw/insn_decode.sv
hw/alu.sv
hw/result_collect.sv
hw/alu_cluster.sv
test/tb_alu_cluster.sv

// File: hw/alu.sv
`default_nettype none

module alu (
  input  alu_pkg::word_t   i_op_a,
  input  alu_pkg::word_t   i_op_b,
  input  alu_pkg::alu_op_t i_alu_op,
  output alu_pkg::word_t   o_alu_data
);
  import alu_pkg::*;

  logic [4:0] shamt;
  word_t      rd_add;
  word_t      rd_sub;
  word_t      rd_sll;
  word_t      rd_slt;
  word_t      rd_sltu;
  word_t      rd_xor;
  word_t      rd_sra;
  word_t      rd_srl;
  word_t      rd_or;
  word_t      rd_and;
  logic       lt_signed;
  logic       lt_unsigned;

  // ===================================================================
  // Arithmetic and compare
  // ===================================================================
  assign rd_add = i_op_a + i_op_b;
  assign rd_sub = i_op_a - i_op_b;

  assign lt_signed   = ($signed(i_op_a) < $signed(i_op_b));
  assign lt_unsigned = (i_op_a < i_op_b);

  assign rd_slt  = {{(XLEN-1){1'b0}}, lt_signed};    // 0 or 1
  assign rd_sltu = {{(XLEN-1){1'b0}}, lt_unsigned};

  // ===================================================================
  // Shifts and bitwise
  // ===================================================================
  // Only the low five bits of B count
  assign shamt = i_op_b[4:0];

  assign rd_sll = i_op_a << shamt;
  assign rd_srl = i_op_a >> shamt;
  assign rd_sra = word_t'($signed(i_op_a) >>> shamt);  // Sign bit fills from the left

  assign rd_xor = i_op_a ^ i_op_b;
  assign rd_or  = i_op_a | i_op_b;
  assign rd_and = i_op_a & i_op_b;

  // Result select, numbering as in the package
  always_comb begin
    case (i_alu_op)
      ALU_ADD:  o_alu_data = rd_add;
      ALU_SUB:  o_alu_data = rd_sub;
      ALU_SLL:  o_alu_data = rd_sll;
      ALU_SLT:  o_alu_data = rd_slt;
      ALU_SLTU: o_alu_data = rd_sltu;
      ALU_XOR:  o_alu_data = rd_xor;
      ALU_SRA:  o_alu_data = rd_sra;
      ALU_SRL:  o_alu_data = rd_srl;
      ALU_OR:   o_alu_data = rd_or;
      ALU_AND:  o_alu_data = rd_and;
      default:  o_alu_data = '0;  // Codes 10 to 15
    endcase
  end

  // Compare results carry only bit 0 through the select
  always_comb begin
    if (i_alu_op == ALU_SLT || i_alu_op == ALU_SLTU) begin
      assert (o_alu_data[XLEN-1:1] == '0)
        else $error("alu: compare result has upper bits set");
    end
  end

endmodule

`default_nettype wire

// File: hw/alu_cluster.sv
`default_nettype none

module alu_cluster (
  input  logic           i_clk,
  input  logic           i_rst,
  input  logic           i_valid,
  input  alu_pkg::insn_t i_insn,
  input  alu_pkg::word_t i_op_a [alu_pkg::NUM_LANES],
  input  alu_pkg::word_t i_op_b [alu_pkg::NUM_LANES],
  output logic           o_valid,
  output logic           o_illegal,
  output alu_pkg::word_t o_result [alu_pkg::NUM_LANES]
);
  import alu_pkg::*;

  // Stage one, registered by the decoder
  logic    s1_valid;
  alu_op_t s1_alu_op;
  logic    s1_illegal;
  word_t   s1_a [NUM_LANES];
  word_t   s1_b [NUM_LANES];

  word_t   lane_result [NUM_LANES];  // Combinational lane outputs

  // ===================================================================
  // Decode stage
  // ===================================================================
  insn_decode u_decode (
    .i_clk     (i_clk),
    .i_rst     (i_rst),
    .i_valid   (i_valid),
    .i_insn    (i_insn),
    .i_op_a    (i_op_a),
    .i_op_b    (i_op_b),
    .o_valid   (s1_valid),
    .o_alu_op  (s1_alu_op),
    .o_illegal (s1_illegal),
    .o_a       (s1_a),
    .o_b       (s1_b)
  );

  // ===================================================================
  // ALU lanes
  // ===================================================================
  for (genvar k = 0; k < NUM_LANES; k++) begin : g_lane
    alu u_alu (
      .i_op_a     (s1_a[k]),
      .i_op_b     (s1_b[k]),
      .i_alu_op   (s1_alu_op),  // Same operation in every lane
      .o_alu_data (lane_result[k])
    );
  end

  // ===================================================================
  // Collect stage
  // ===================================================================
  result_collect u_collect (
    .i_clk         (i_clk),
    .i_rst         (i_rst),
    .i_valid       (s1_valid),
    .i_illegal     (s1_illegal),
    .i_lane_result (lane_result),
    .o_valid       (o_valid),
    .o_illegal     (o_illegal),
    .o_result      (o_result)
  );

endmodule

`default_nettype wire

// File: hw/alu_pkg.sv
`default_nettype none

package alu_pkg;

  // ===================================================================
  // Cluster shape
  // ===================================================================
  localparam int NUM_LANES = 4;
  localparam int XLEN      = 32;

  typedef logic [XLEN-1:0] word_t;    // One data word
  typedef logic [31:0]     insn_t;    // One instruction word
  typedef logic [3:0]      alu_op_t;  // ALU operation code
  typedef logic [6:0]      opcode_t;  // Opcode field

  // ===================================================================
  // ALU operation codes
  // ===================================================================
  localparam alu_op_t ALU_ADD  = 4'd0;
  localparam alu_op_t ALU_SUB  = 4'd1;
  localparam alu_op_t ALU_SLL  = 4'd2;
  localparam alu_op_t ALU_SLT  = 4'd3;
  localparam alu_op_t ALU_SLTU = 4'd4;
  localparam alu_op_t ALU_XOR  = 4'd5;
  localparam alu_op_t ALU_SRA  = 4'd6;
  localparam alu_op_t ALU_SRL  = 4'd7;
  localparam alu_op_t ALU_OR   = 4'd8;
  localparam alu_op_t ALU_AND  = 4'd9;
  localparam alu_op_t ALU_ZERO = 4'd10;  // First of the zero codes

  // ===================================================================
  // Instruction fields
  // ===================================================================
  localparam opcode_t OPC_OP     = 7'b0110011;
  localparam opcode_t OPC_OP_IMM = 7'b0010011;

  localparam logic [2:0] F3_ADD  = 3'b000;
  localparam logic [2:0] F3_SLL  = 3'b001;
  localparam logic [2:0] F3_SLT  = 3'b010;
  localparam logic [2:0] F3_SLTU = 3'b011;
  localparam logic [2:0] F3_XOR  = 3'b100;
  localparam logic [2:0] F3_SR   = 3'b101;  // SRL or SRA by funct7
  localparam logic [2:0] F3_OR   = 3'b110;
  localparam logic [2:0] F3_AND  = 3'b111;

  localparam logic [6:0] F7_BASE = 7'b0000000;
  localparam logic [6:0] F7_ALT  = 7'b0100000;  // SUB and SRA

endpackage

`default_nettype wire

// File: hw/insn_decode.sv
`default_nettype none

module insn_decode (
  input  logic             i_clk,
  input  logic             i_rst,
  input  logic             i_valid,
  input  alu_pkg::insn_t   i_insn,
  input  alu_pkg::word_t   i_op_a [alu_pkg::NUM_LANES],
  input  alu_pkg::word_t   i_op_b [alu_pkg::NUM_LANES],
  output logic             o_valid,
  output alu_pkg::alu_op_t o_alu_op,
  output logic             o_illegal,
  output alu_pkg::word_t   o_a [alu_pkg::NUM_LANES],
  output alu_pkg::word_t   o_b [alu_pkg::NUM_LANES]
);
  import alu_pkg::*;

  opcode_t    opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  word_t      imm_i;
  logic       is_op;
  logic       is_op_imm;
  alu_op_t    base_op;
  alu_op_t    dec_op;
  logic       dec_illegal;

  assign opcode    = i_insn[6:0];
  assign funct3    = i_insn[14:12];
  assign funct7    = i_insn[31:25];
  assign imm_i     = {{(XLEN-12){i_insn[31]}}, i_insn[31:20]};  // I-type, sign extended
  assign is_op     = (opcode == OPC_OP);
  assign is_op_imm = (opcode == OPC_OP_IMM);

  // Shared by both formats
  always_comb begin
    base_op = ALU_ADD;
    case (funct3)
      F3_ADD:  base_op = ALU_ADD;
      F3_SLL:  base_op = ALU_SLL;
      F3_SLT:  base_op = ALU_SLT;
      F3_SLTU: base_op = ALU_SLTU;
      F3_XOR:  base_op = ALU_XOR;
      F3_SR:   base_op = ALU_SRL;  // Arithmetic variant picked below
      F3_OR:   base_op = ALU_OR;
      F3_AND:  base_op = ALU_AND;
    endcase
  end

  // ===================================================================
  // Legality and funct7 alternates
  // ===================================================================
  always_comb begin
    dec_op      = base_op;
    dec_illegal = 1'b0;
    if (is_op) begin
      if (funct7 == F7_ALT) begin
        if (funct3 == F3_ADD) begin
          dec_op = ALU_SUB;
        end else if (funct3 == F3_SR) begin
          dec_op = ALU_SRA;
        end else begin
          dec_illegal = 1'b1;
        end
      end else if (funct7 != F7_BASE) begin
        dec_illegal = 1'b1;
      end
    end else if (is_op_imm) begin
      case (funct3)
        F3_SLL: dec_illegal = (funct7 != F7_BASE);
        F3_SR: begin
          if (funct7 == F7_ALT) begin
            dec_op = ALU_SRA;
          end else if (funct7 != F7_BASE) begin
            dec_illegal = 1'b1;
          end
        end
        F3_ADD:  dec_illegal = (funct7 == F7_ALT);  // SUB pattern on ADDI is rejected
        default: dec_illegal = 1'b0;                // funct7 is plain immediate here
      endcase
    end else begin
      dec_illegal = 1'b1;  // Opcode outside the cluster
    end
    if (dec_illegal) begin
      dec_op = ALU_ZERO;  // Lanes then give zero
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_valid   <= 1'b0;
      o_illegal <= 1'b0;
      o_alu_op  <= ALU_ZERO;
    end else begin
      o_valid   <= i_valid;
      o_illegal <= i_valid & dec_illegal;
      if (i_valid) begin
        o_alu_op <= dec_op;
      end
    end
  end

  // Operand capture, immediate replaces B in every lane
  always_ff @(posedge i_clk) begin
    if (i_valid) begin
      for (int k = 0; k < NUM_LANES; k++) begin
        o_a[k] <= i_op_a[k];
        o_b[k] <= is_op_imm ? imm_i : i_op_b[k];
      end
    end
  end

  a_illegal_with_valid : assert property (
    @(posedge i_clk) disable iff (i_rst) o_illegal |-> o_valid
  ) else $error("insn_decode: illegal flag without stage valid");

endmodule

`default_nettype wire

// File: hw/result_collect.sv
`default_nettype none

module result_collect (
  input  logic           i_clk,
  input  logic           i_rst,
  input  logic           i_valid,
  input  logic           i_illegal,
  input  alu_pkg::word_t i_lane_result [alu_pkg::NUM_LANES],
  output logic           o_valid,
  output logic           o_illegal,
  output alu_pkg::word_t o_result [alu_pkg::NUM_LANES]
);
  import alu_pkg::*;

  // ===================================================================
  // Output stage
  // ===================================================================
  // Results and flag hold between strobes
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_valid   <= 1'b0;
      o_illegal <= 1'b0;
      for (int k = 0; k < NUM_LANES; k++) begin
        o_result[k] <= '0;
      end
    end else begin
      o_valid <= i_valid;  // One-cycle strobe
      if (i_valid) begin
        o_illegal <= i_illegal;
        for (int k = 0; k < NUM_LANES; k++) begin
          o_result[k] <= i_lane_result[k];
        end
      end
    end
  end

  // Each stage-one strobe gives exactly one output strobe, one cycle on
  a_valid_follow : assert property (
    @(posedge i_clk) disable iff (i_rst) 1'b1 |=> (o_valid == $past(i_valid))
  ) else $error("result_collect: output valid out of step with input valid");

endmodule

`default_nettype wire

// File: test/alu_cluster_golden.txt
# insn a0 a1 a2 a3 b0 b1 b2 b3 exp0 exp1 exp2 exp3 illegal
# All fields hex, lanes 0 to 3, illegal is 0 or 1
# Register ops: ADD SUB SLL SLT SLTU XOR SRL SRA OR AND
002081B3 00000005 80000000 FFFFFFFF 7FFFFFFF 00000003 00000001 00000000 FFFFFFFF 00000008 80000001 FFFFFFFF 7FFFFFFE 0
402081B3 00000005 80000000 FFFFFFFF 7FFFFFFF 00000003 00000001 00000000 FFFFFFFF 00000002 7FFFFFFF FFFFFFFF 80000000 0
002091B3 00000005 80000000 FFFFFFFF 7FFFFFFF 00000003 00000001 00000000 FFFFFFFF 00000028 00000000 FFFFFFFF 80000000 0
0020A1B3 00000005 80000000 FFFFFFFF 7FFFFFFF 00000003 00000001 00000000 FFFFFFFF 00000000 00000001 00000001 00000000 0
0020B1B3 00000005 80000000 FFFFFFFF 7FFFFFFF 00000003 00000001 00000000 FFFFFFFF 00000000 00000000 00000000 00000001 0
0020C1B3 00000005 80000000 FFFFFFFF 7FFFFFFF 00000003 00000001 00000000 FFFFFFFF 00000006 80000001 FFFFFFFF 80000000 0
0020D1B3 00000005 80000000 FFFFFFFF 7FFFFFFF 00000003 00000001 00000000 FFFFFFFF 00000000 40000000 FFFFFFFF 00000000 0
4020D1B3 00000005 80000000 FFFFFFFF 7FFFFFFF 00000003 00000001 00000000 FFFFFFFF 00000000 C0000000 FFFFFFFF 00000000 0
0020E1B3 00000005 80000000 FFFFFFFF 7FFFFFFF 00000003 00000001 00000000 FFFFFFFF 00000007 80000001 FFFFFFFF FFFFFFFF 0
0020F1B3 00000005 80000000 FFFFFFFF 7FFFFFFF 00000003 00000001 00000000 FFFFFFFF 00000001 00000000 00000000 7FFFFFFF 0
# Signed and unsigned compare edges, SUB wrap
0020A1B3 FFFFFFFF 00000001 80000000 00000000 00000001 FFFFFFFF 7FFFFFFF 00000000 00000001 00000000 00000001 00000000 0
0020B1B3 FFFFFFFF 00000001 80000000 00000000 00000001 FFFFFFFF 7FFFFFFF 00000000 00000000 00000001 00000000 00000000 0
402081B3 FFFFFFFF 00000001 80000000 00000000 00000001 FFFFFFFF 7FFFFFFF 00000000 FFFFFFFE 00000002 00000001 00000000 0
# Register shifts with B above 31
002091B3 12345678 80000000 F0000000 0000FFFF 00000024 00000021 FFFFFFE4 00000020 23456780 00000000 00000000 0000FFFF 0
0020D1B3 12345678 80000000 F0000000 0000FFFF 00000024 00000021 FFFFFFE4 00000020 01234567 40000000 0F000000 0000FFFF 0
4020D1B3 12345678 80000000 F0000000 0000FFFF 00000024 00000021 FFFFFFE4 00000020 01234567 C0000000 FF000000 0000FFFF 0
# Immediate ops, B inputs are ignored
FFF08193 00000000 FFFFFFFF 80000000 7FFFFFFF DEADBEEF 0BADF00D 12345678 FFFFFFFF FFFFFFFF FFFFFFFE 7FFFFFFF 7FFFFFFE 0
FFF0A193 00000000 FFFFFFFF 80000000 7FFFFFFF DEADBEEF 0BADF00D 12345678 FFFFFFFF 00000000 00000000 00000001 00000000 0
0050A193 00000000 FFFFFFFF 80000000 7FFFFFFF DEADBEEF 0BADF00D 12345678 FFFFFFFF 00000001 00000001 00000001 00000000 0
FFF0B193 00000000 FFFFFFFF 80000000 7FFFFFFF DEADBEEF 0BADF00D 12345678 FFFFFFFF 00000001 00000000 00000001 00000001 0
F000C193 00000000 FFFFFFFF 80000000 7FFFFFFF DEADBEEF 0BADF00D 12345678 FFFFFFFF FFFFFF00 000000FF 7FFFFF00 800000FF 0
8000E193 00000000 FFFFFFFF 80000000 7FFFFFFF DEADBEEF 0BADF00D 12345678 FFFFFFFF FFFFF800 FFFFFFFF FFFFF800 FFFFFFFF 0
FF00F193 00000000 FFFFFFFF 80000000 7FFFFFFF DEADBEEF 0BADF00D 12345678 FFFFFFFF 00000000 FFFFFFF0 80000000 7FFFFFF0 0
00409193 00000000 FFFFFFFF 80000000 7FFFFFFF DEADBEEF 0BADF00D 12345678 FFFFFFFF 00000000 FFFFFFF0 00000000 FFFFFFF0 0
0040D193 00000000 FFFFFFFF 80000000 7FFFFFFF DEADBEEF 0BADF00D 12345678 FFFFFFFF 00000000 0FFFFFFF 08000000 07FFFFFF 0
4040D193 00000000 FFFFFFFF 80000000 7FFFFFFF DEADBEEF 0BADF00D 12345678 FFFFFFFF 00000000 FFFFFFFF F8000000 07FFFFFF 0
# Illegal encodings give zero, then a legal ADD
123450B7 11111111 22222222 33333333 44444444 55555555 66666666 77777777 88888888 00000000 00000000 00000000 00000000 1
4020F1B3 11111111 22222222 33333333 44444444 55555555 66666666 77777777 88888888 00000000 00000000 00000000 00000000 1
40008193 11111111 22222222 33333333 44444444 55555555 66666666 77777777 88888888 00000000 00000000 00000000 00000000 1
022081B3 11111111 22222222 33333333 44444444 55555555 66666666 77777777 88888888 00000000 00000000 00000000 00000000 1
40409193 11111111 22222222 33333333 44444444 55555555 66666666 77777777 88888888 00000000 00000000 00000000 00000000 1
00000000 11111111 22222222 33333333 44444444 55555555 66666666 77777777 88888888 00000000 00000000 00000000 00000000 1
002081B3 11111111 22222222 33333333 44444444 55555555 66666666 77777777 88888888 66666666 88888888 AAAAAAAA CCCCCCCC 0

// File: test/tb_alu_cluster.sv
`default_nettype none

module tb_alu_cluster;
  timeunit 1ns;
  timeprecision 1ps;
  import alu_pkg::*;

  localparam int    TIMEOUT_CYCLES = 100;
  localparam int    BURST_LEN      = 10;  // Leading vectors go back to back
  localparam int    NUM_FIELDS     = 3 * NUM_LANES + 2;
  localparam string VEC_FILE       = "test/alu_cluster_golden.txt";

  logic  i_clk;
  logic  i_rst;
  logic  i_valid;
  insn_t i_insn;
  word_t i_op_a [NUM_LANES];
  word_t i_op_b [NUM_LANES];
  logic  o_valid;
  logic  o_illegal;
  word_t o_result [NUM_LANES];

  // Golden vectors with lane values stored flat
  insn_t vec_insn [$];
  word_t vec_a    [$];
  word_t vec_b    [$];
  word_t vec_exp  [$];
  logic  vec_ill  [$];

  int     pend_idx [$];  // Operations in flight in input order
  int     pend_cyc [$];  // Edge that drove each input
  int     cyc_count  = 0;
  int     drive_idx  = 0;
  int     err_count  = 0;
  int     test_count = 0;
  int     test_fail  = 0;
  integer seed;

  alu_cluster uut (
    .i_clk     (i_clk),
    .i_rst     (i_rst),
    .i_valid   (i_valid),
    .i_insn    (i_insn),
    .i_op_a    (i_op_a),
    .i_op_b    (i_op_b),
    .o_valid   (o_valid),
    .o_illegal (o_illegal),
    .o_result  (o_result)
  );

  initial begin
    i_clk = 1'b0;
    forever #10 i_clk = ~i_clk;
  end

  always @(posedge i_clk) cyc_count <= cyc_count + 1;

  // ====================================================================
  // Helpers
  // ====================================================================
  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      err_count++;
      $display("ERROR time %0t: %s expected %h actual %h", $time, name, expected, actual);
    end
  endtask

  task automatic load_vectors();
    int          fd;
    int          n;
    string       line;
    logic [31:0] f [NUM_FIELDS];
    fd = $fopen(VEC_FILE, "r");
    if (fd == 0) begin
      err_count++;
      $display("Could not open the vector file %s", VEC_FILE);
    end else begin
      while ($fgets(line, fd) != 0) begin
        if (line.len() > 0 && line[0] != "#") begin
          n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                      f[0], f[1], f[2], f[3], f[4], f[5], f[6],
                      f[7], f[8], f[9], f[10], f[11], f[12], f[13]);
          if (n == NUM_FIELDS) begin
            vec_insn.push_back(f[0]);
            for (int k = 0; k < NUM_LANES; k++) begin
              vec_a.push_back(f[1 + k]);
              vec_b.push_back(f[1 + NUM_LANES + k]);
              vec_exp.push_back(f[1 + 2 * NUM_LANES + k]);
            end
            vec_ill.push_back(f[NUM_FIELDS - 1][0]);
          end else if (n > 0) begin
            err_count++;
            $display("Malformed vector line skipped: %s", line);
          end
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic expect_reset_values();
    check_value("o_valid", 32'd0, 32'(o_valid));
    check_value("o_illegal", 32'd0, 32'(o_illegal));
    for (int k = 0; k < NUM_LANES; k++) begin
      check_value($sformatf("o_result[%0d]", k), 32'd0, o_result[k]);
    end
  endtask

  task automatic score_output();
    int idx;
    int start;
    int errs_before;
    if (pend_idx.size() == 0) begin
      err_count++;
      $display("Output valid at time %0t with no operation in flight", $time);
    end else begin
      idx         = pend_idx.pop_front();
      start       = pend_cyc.pop_front();
      errs_before = err_count;
      check_value("latency", 32'd2, 32'(cyc_count - start));  // Cycles after the driving edge
      for (int k = 0; k < NUM_LANES; k++) begin
        check_value($sformatf("o_result[%0d]", k), vec_exp[idx * NUM_LANES + k], o_result[k]);
      end
      check_value("o_illegal", 32'(vec_ill[idx]), 32'(o_illegal));
      test_count++;
      if (err_count == errs_before) begin
        $display("Test %0d insn %h: pass", idx, vec_insn[idx]);
      end else begin
        test_fail++;
        $display("Test %0d insn %h: FAIL", idx, vec_insn[idx]);
      end
    end
  endtask

  // Outputs are sampled away from the driving edge
  always @(negedge i_clk) begin
    if (!i_rst) begin
      if (o_valid) score_output();
      if (i_valid) begin
        pend_idx.push_back(drive_idx);
        pend_cyc.push_back(cyc_count);  // Edge that put it on the inputs
      end
    end
  end

  // ====================================================================
  // Stimulus
  // ====================================================================
  initial begin
    int gap;
    int wait_cycles;
    int reset_errs;
    seed    = 32'h18d8ddb3;
    i_rst   <= 1'b1;
    i_valid <= 1'b0;
    i_insn  <= '0;
    for (int k = 0; k < NUM_LANES; k++) begin
      i_op_a[k] <= '0;
      i_op_b[k] <= '0;
    end
    load_vectors();

    if (vec_insn.size() == 0) begin
      err_count++;
      $display("No vectors loaded, stimulus skipped");
    end else begin
      // Four reset edges, then two idle cycles
      reset_errs = err_count;
      for (int c = 0; c < 6; c++) begin
        @(posedge i_clk);
        if (c == 3) i_rst <= 1'b0;
        @(negedge i_clk);
        expect_reset_values();
      end
      test_count++;
      if (err_count == reset_errs) begin
        $display("Test reset: pass");
      end else begin
        test_fail++;
        $display("Test reset: FAIL");
      end

      for (int v = 0; v < vec_insn.size(); v++) begin
        @(posedge i_clk);
        i_valid   <= 1'b1;
        i_insn    <= vec_insn[v];
        drive_idx <= v;
        for (int k = 0; k < NUM_LANES; k++) begin
          i_op_a[k] <= vec_a[v * NUM_LANES + k];
          i_op_b[k] <= vec_b[v * NUM_LANES + k];
        end
        if (v < BURST_LEN) gap = 0;
        else gap = $random(seed) & 3;
        if (gap > 0) begin
          @(posedge i_clk);
          i_valid <= 1'b0;
          repeat (gap - 1) @(posedge i_clk);
        end
      end
      @(posedge i_clk);
      i_valid <= 1'b0;

      wait_cycles = 0;
      while (pend_idx.size() != 0 && wait_cycles < TIMEOUT_CYCLES) begin
        @(posedge i_clk);
        wait_cycles++;
      end
      if (pend_idx.size() != 0) begin
        err_count++;
        $display("Timeout, no output valid within %0d cycles", TIMEOUT_CYCLES);
      end
      repeat (3) @(posedge i_clk);  // Room for a stray strobe
    end

    $display("Tests run: %0d, failed: %0d, mismatches: %0d", test_count, test_fail, err_count);
    if (err_count == 0 && test_fail == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

`default_nettype wire
